// ==== hw/alu_pkg.sv ====
package alu_pkg;

    // bit 4 is the carry-in or shift-in and is left at zero here
    typedef enum logic [4:0] {
        ADD   = 5'b00000,  // A equal to B gives a left shift
        SUB   = 5'b11000,  // carry comes out as the inverted borrow
        XOR   = 5'b00100,
        XNOR  = 5'b01100,  // with A at zero this is NOT B
        COMP  = 5'b01000,  // A-B-1 so a carry means A is greater than B
        AND   = 5'b00101,
        OR    = 5'b00110,
        RSHFT = 5'b00111   // B moves right by one and A is ignored
    } alu_cmd_e;

    // field view of the same five command bits
    typedef struct packed {
        logic       carry_in;       // also the bit shifted in at the top
        logic       b_inv;          // invert operand B before the adder
        logic       carry_disable;  // logical ops ignore the carry chain
        logic [1:0] mux_sel;        // per-bit result select
    } alu_ctrl_t;

    localparam int SLICE_WIDTH = 4;

    // register map of the AXI4-Lite slave
    localparam logic [31:0] ADDR_OPA    = 32'h00;
    localparam logic [31:0] ADDR_OPB    = 32'h04;
    localparam logic [31:0] ADDR_CMD    = 32'h08;
    localparam logic [31:0] ADDR_RESULT = 32'h0C;
    localparam logic [31:0] ADDR_FLAGS  = 32'h10;

    // bit positions in the flags register
    localparam int FLAG_CARRY = 0;
    localparam int FLAG_ZERO  = 1;
    localparam int FLAG_ONES  = 2;
    localparam int FLAG_SIGN  = 3;

endpackage

// ==== hw/alu_slice.sv ====
`timescale 1ns/10ps

module alu_slice (
    input  logic [alu_pkg::SLICE_WIDTH-1:0] opa,
    input  logic [alu_pkg::SLICE_WIDTH-1:0] opb,
    input  alu_pkg::alu_ctrl_t              cmd,
    input  logic                            carry_in,
    input  logic                            shift_in,
    output logic [alu_pkg::SLICE_WIDTH-1:0] res,
    output logic                            carry_out,
    output logic                            shift_out
);
    import alu_pkg::*;

    logic [SLICE_WIDTH-1:0] b_x;        // operand B after optional inversion
    logic [SLICE_WIDTH-1:0] gen;
    logic [SLICE_WIDTH-1:0] prop;
    logic [SLICE_WIDTH-1:0] right_bit;  // neighbour bit used by the shift
    logic [SLICE_WIDTH-1:0] mux_out;
    logic [SLICE_WIDTH:0]   carry;

    assign b_x       = opb ^ {SLICE_WIDTH{cmd.b_inv}};
    assign gen       = opa & b_x;
    assign prop      = opa | b_x;       // OR works as propagate since gen covers the AND case
    assign right_bit = {shift_in, b_x[SLICE_WIDTH-1:1]};
    assign shift_out = b_x[0];          // feeds the top bit of the slice below

    // every carry is a flat sum of products on carry_in, gen and prop
    always_comb begin : lookahead
        logic term;
        carry[0] = carry_in;
        for (int i = 0; i < SLICE_WIDTH; i++) begin
            term = carry_in;
            for (int j = 0; j <= i; j++) begin
                term = term & prop[j];
            end
            carry[i+1] = term;
            for (int j = 0; j <= i; j++) begin
                term = gen[j];
                for (int k = j + 1; k <= i; k++) begin
                    term = term & prop[k];
                end
                carry[i+1] = carry[i+1] | term;
            end
        end
    end

    assign carry_out = carry[SLICE_WIDTH];

    always_comb begin
        for (int i = 0; i < SLICE_WIDTH; i++) begin
            case (cmd.mux_sel)
                2'b00:   mux_out[i] = ~gen[i] & prop[i];  // half sum
                2'b01:   mux_out[i] = gen[i];
                2'b10:   mux_out[i] = prop[i];
                default: mux_out[i] = right_bit[i];
            endcase
        end
    end

    // the carry only enters the sum for arithmetic commands
    assign res = mux_out ^ (carry[SLICE_WIDTH-1:0] & {SLICE_WIDTH{~cmd.carry_disable}});

    // the command comes from the register front end which clears it in reset,
    // so once the operands are known it must be known too
    always_comb begin
        if (!$isunknown({opa, opb})) begin
            assert (!$isunknown(cmd))
                else $error("alu_slice sees an unknown command with known operands");
        end
    end

endmodule

// ==== hw/alu_axil_regs.sv ====
`timescale 1ns/10ps

module alu_axil_regs #(
    parameter int num_slices = 4
) (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        wvalid,
    output logic        wready,
    output logic [1:0]  bresp,
    output logic        bvalid,
    input  logic        bready,
    input  logic [31:0] araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  logic        rready,
    output logic [alu_pkg::SLICE_WIDTH*num_slices-1:0] opa,
    output logic [alu_pkg::SLICE_WIDTH*num_slices-1:0] opb,
    output alu_pkg::alu_ctrl_t                         cmd,
    output logic                                       start,
    input  logic [alu_pkg::SLICE_WIDTH*num_slices-1:0] result,
    input  logic [3:0]                                 flags
);
    import alu_pkg::*;

    localparam int data_w = SLICE_WIDTH * num_slices;
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    logic        wr_accept;
    logic        wr_fire;
    logic        wr_take;
    logic        wr_known;
    logic        cmd_write;
    logic        rd_fire;
    logic        rd_known;
    logic [31:0] rd_word;

    // a pending response covers both bvalid and the start cycle of a command
    assign wr_accept = awvalid && wvalid && !awready && !bvalid && !start;
    assign wr_fire   = awvalid && wvalid && awready && wready;
    assign wr_take   = wr_fire && (wstrb != 4'b0000);  // any lane set writes the full word
    assign wr_known  = awaddr inside {ADDR_OPA, ADDR_OPB, ADDR_CMD, ADDR_RESULT, ADDR_FLAGS};
    assign cmd_write = wr_take && (awaddr == ADDR_CMD);

    always_ff @(posedge clk) begin
        if (reset) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            start   <= 1'b0;
            opa     <= '0;
            opb     <= '0;
            cmd     <= '0;
        end else begin
            awready <= wr_accept;
            wready  <= wr_accept;
            start   <= cmd_write;  // single cycle strobe
            if (wr_take && awaddr == ADDR_OPA) begin
                opa <= wdata[data_w-1:0];
            end
            if (wr_take && awaddr == ADDR_OPB) begin
                opb <= wdata[data_w-1:0];
            end
            if (cmd_write) begin
                cmd <= alu_ctrl_t'(wdata[4:0]);
            end
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
            if (start || (wr_fire && !cmd_write)) begin
                bvalid <= 1'b1;  // a command answers on the edge the collector captures
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            bresp <= wr_known ? RESP_OKAY : RESP_SLVERR;
        end
    end

    assign arready = !rvalid;  // one read in flight at a time
    assign rd_fire = arvalid && arready;

    always_comb begin
        rd_known = 1'b1;
        case (araddr)
            ADDR_OPA:    rd_word = 32'(opa);
            ADDR_OPB:    rd_word = 32'(opb);
            ADDR_CMD:    rd_word = 32'(cmd);
            ADDR_RESULT: rd_word = 32'(result);
            ADDR_FLAGS:  rd_word = 32'(flags);
            default: begin
                rd_word  = '0;
                rd_known = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rvalid <= 1'b0;
        end else if (rd_fire) begin
            rvalid <= 1'b1;
        end else if (rvalid && rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rdata <= rd_word;
            rresp <= rd_known ? RESP_OKAY : RESP_SLVERR;
        end
    end

    a_bvalid_hold: assert property (@(posedge clk) disable iff (reset)
        bvalid && !bready |=> bvalid && $stable(bresp));

    a_rdata_hold: assert property (@(posedge clk) disable iff (reset)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));

    a_start_idle: assert property (@(posedge clk) disable iff (reset)
        $rose(start) |-> !bvalid);

endmodule

// ==== hw/alu_result_collect.sv ====
`timescale 1ns/10ps

module alu_result_collect #(
    parameter int num_slices = 4
) (
    input  logic                                       clk,
    input  logic                                       reset,
    input  logic                                       start,
    input  logic [alu_pkg::SLICE_WIDTH*num_slices-1:0] res,
    input  logic                                       carry_out,
    input  alu_pkg::alu_ctrl_t                         cmd,
    output logic [alu_pkg::SLICE_WIDTH*num_slices-1:0] result,
    output logic [3:0]                                 flags
);
    import alu_pkg::*;

    localparam int data_w = SLICE_WIDTH * num_slices;

    logic [3:0] next_flags;

    // flags are derived from the same slice outputs that get captured
    always_comb begin
        next_flags             = '0;
        next_flags[FLAG_CARRY] = carry_out & ~cmd.carry_disable;  // logical ops report no carry
        next_flags[FLAG_ZERO]  = (res == '0);
        next_flags[FLAG_ONES]  = &res;                 // A equals B during COMP
        next_flags[FLAG_SIGN]  = res[data_w-1];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            result <= '0;
            flags  <= '0;
        end else if (start) begin
            result <= res;
            flags  <= next_flags;
        end
    end

    // the front end must wait for the response before it can start again
    a_start_single: assert property (@(posedge clk) disable iff (reset)
        start |=> !start);

endmodule

// ==== hw/alu_coproc_top.sv ====
`timescale 1ns/10ps

module alu_coproc_top #(
    parameter int num_slices = 4
) (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        wvalid,
    output logic        wready,
    output logic [1:0]  bresp,
    output logic        bvalid,
    input  logic        bready,
    input  logic [31:0] araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  logic        rready
);
    import alu_pkg::*;

    localparam int data_w = SLICE_WIDTH * num_slices;

    logic [data_w-1:0]   opa;
    logic [data_w-1:0]   opb;
    logic [data_w-1:0]   res;
    logic [data_w-1:0]   result;
    logic [3:0]          flags;
    alu_ctrl_t           cmd;
    logic                start;
    logic [num_slices:0] carry_chain;  // ripples upward between slices
    logic [num_slices:0] shift_chain;  // runs downward for the right shift

    assign carry_chain[0]          = cmd.carry_in;
    assign shift_chain[num_slices] = cmd.carry_in;

    alu_axil_regs #(
        .num_slices(num_slices)
    ) alu_axil_regs_i (
        .clk, .reset,
        .awaddr, .awvalid, .awready,
        .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready,
        .rdata, .rresp, .rvalid, .rready,
        .opa, .opb, .cmd, .start, .result, .flags
    );

    for (genvar k = 0; k < num_slices; k++) begin : g_slice
        alu_slice alu_slice_i (
            .opa       (opa[k*SLICE_WIDTH +: SLICE_WIDTH]),
            .opb       (opb[k*SLICE_WIDTH +: SLICE_WIDTH]),
            .cmd       (cmd),
            .carry_in  (carry_chain[k]),
            .shift_in  (shift_chain[k+1]),
            .res       (res[k*SLICE_WIDTH +: SLICE_WIDTH]),
            .carry_out (carry_chain[k+1]),
            .shift_out (shift_chain[k])
        );
    end

    alu_result_collect #(
        .num_slices(num_slices)
    ) alu_result_collect_i (
        .clk, .reset, .start, .res,
        .carry_out (carry_chain[num_slices]),
        .cmd, .result, .flags
    );

endmodule

// ==== sim/alu_coproc_tb.sv ====
`timescale 1ns/10ps

module alu_coproc_tb;
    import alu_pkg::*;

    localparam int          num_slices   = 4;
    localparam int          data_w       = SLICE_WIDTH * num_slices;
    localparam logic [1:0]  RESP_OKAY    = 2'b00;
    localparam logic [1:0]  RESP_SLVERR  = 2'b10;
    localparam logic [31:0] ADDR_UNKNOWN = 32'h40;  // outside the register map

    logic        clk = 1'b0;
    logic        reset;
    logic [31:0] awaddr, wdata, araddr, rdata;
    logic [3:0]  wstrb;
    logic [1:0]  bresp, rresp;
    logic        awvalid, awready, wvalid, wready, bvalid, bready;
    logic        arvalid, arready, rvalid, rready;

    alu_ctrl_t         vec_cmd[$];
    logic [data_w-1:0] vec_a[$];
    logic [data_w-1:0] vec_b[$];
    logic [data_w-1:0] vec_res[$];
    logic [3:0]        vec_flags[$];
    int                cycle_count = 0;
    int                cycle_limit = 2000;  // raised once the vectors are loaded

    alu_coproc_top #(.num_slices(num_slices)) alu_coproc_top_i (.*);

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            stop_run($sformatf("timeout, the run did not finish in %0d cycles", cycle_limit));
        end
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic ensure(input logic cond, input string why);
        if (cond !== 1'b1) begin
            stop_run($sformatf("at %0t: %s", $time, why));
        end
    endtask

    task automatic check_result(input string name, input logic [data_w-1:0] got,
                                input logic [data_w-1:0] exp);
        if (got !== exp) begin
            stop_run($sformatf("MISMATCH at %0t: %s is %h, expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_flags(input string name, input logic [3:0] got, input logic [3:0] exp);
        if (got !== exp) begin
            stop_run($sformatf("MISMATCH at %0t: %s is %h, expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
        if (got !== exp) begin
            stop_run($sformatf("MISMATCH at %0t: %s is %h, expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_cmd(input string name, input alu_ctrl_t got, input alu_ctrl_t exp);
        if (got !== exp) begin
            stop_run($sformatf("MISMATCH at %0t: %s is %h, expected %h", $time, name, got, exp));
        end
    endtask

    // every task starts and ends 1 ns after a rising edge
    task automatic step_cycle;
        @(posedge clk);
        #1;
    endtask

    task automatic write_reg(input logic [31:0] addr, input logic [31:0] data,
                             input logic [1:0] exp_resp);
        int         stall;
        logic [1:0] held;
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        while (!(awready && wready)) begin
            step_cycle();
        end
        step_cycle();  // the handshake happens on this edge
        awvalid = 1'b0;
        wvalid  = 1'b0;
        while (!bvalid) begin
            step_cycle();
        end
        held  = bresp;
        stall = $urandom % 4;
        repeat (stall) begin
            step_cycle();
            ensure(bvalid, "bvalid dropped while bready was low");
            check_resp("bresp", bresp, held);
        end
        bready = 1'b1;
        step_cycle();
        bready = 1'b0;
        ensure(!bvalid, "bvalid stayed high after the response was taken");
        check_resp("bresp", held, exp_resp);
    endtask

    // the next write waits on the bus while the first response is held back
    task automatic write_under_backpressure(input logic [31:0] addr, input logic [31:0] first,
                                            input logic [31:0] second);
        awaddr  = addr;
        wdata   = first;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        while (!(awready && wready)) begin
            step_cycle();
        end
        step_cycle();
        wdata = second;  // awvalid and wvalid stay high for the second write
        while (!bvalid) begin
            step_cycle();
        end
        repeat (3) begin
            step_cycle();
            ensure(bvalid, "bvalid dropped while bready was low");
            ensure(!awready && !wready, "a write was accepted while a response was pending");
        end
        check_resp("bresp", bresp, RESP_OKAY);
        bready = 1'b1;
        step_cycle();
        bready = 1'b0;
        ensure(!bvalid, "bvalid stayed high after the response was taken");
        write_reg(addr, second, RESP_OKAY);
    endtask

    task automatic read_reg(input logic [31:0] addr, input logic [1:0] exp_resp,
                            output logic [31:0] data);
        int          stall;
        logic [1:0]  held_resp;
        araddr  = addr;
        arvalid = 1'b1;
        while (!arready) begin
            step_cycle();
        end
        step_cycle();
        arvalid = 1'b0;
        while (!rvalid) begin
            step_cycle();
        end
        data      = rdata;
        held_resp = rresp;
        stall     = $urandom % 4;
        repeat (stall) begin
            step_cycle();
            ensure(rvalid, "rvalid dropped while rready was low");
            ensure(!arready, "arready rose while read data was waiting");
            check_result("rdata", rdata[data_w-1:0], data[data_w-1:0]);
            check_resp("rresp", rresp, held_resp);
        end
        rready = 1'b1;
        step_cycle();
        rready = 1'b0;
        check_resp("rresp", held_resp, exp_resp);
    endtask

    initial begin
        int          fd;
        int          fields;
        string       line;
        logic [31:0] f_cmd, f_a, f_b, f_res, f_flags;
        logic [31:0] word;

        void'($urandom(99));  // one seed for all stall lengths
        reset   = 1'b1;
        awaddr  = '0;
        wdata   = '0;
        wstrb   = 4'hf;
        araddr  = '0;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        arvalid = 1'b0;
        rready  = 1'b0;

        fd = $fopen("sim/alu_vectors.txt", "r");
        if (fd == 0) begin
            stop_run("cannot open sim/alu_vectors.txt");
        end
        while ($fgets(line, fd) != 0) begin
            fields = $sscanf(line, "%h %h %h %h %h", f_cmd, f_a, f_b, f_res, f_flags);
            if (fields == 5) begin
                vec_cmd.push_back(alu_ctrl_t'(f_cmd[4:0]));
                vec_a.push_back(f_a[data_w-1:0]);
                vec_b.push_back(f_b[data_w-1:0]);
                vec_res.push_back(f_res[data_w-1:0]);
                vec_flags.push_back(f_flags[3:0]);
            end else if (fields > 0) begin
                stop_run($sformatf("malformed vector line: %s", line));
            end
        end
        $fclose(fd);
        ensure(vec_cmd.size() > 0, "the vector file holds no vectors");
        cycle_limit = 200 * vec_cmd.size() + 2000;

        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;

        ensure(!bvalid && !rvalid && arready, "handshake outputs are wrong after reset");
        read_reg(ADDR_RESULT, RESP_OKAY, word);
        check_result("result", word[data_w-1:0], '0);
        read_reg(ADDR_FLAGS, RESP_OKAY, word);
        check_flags("flags", word[3:0], 4'h0);

        for (int i = 0; i < vec_cmd.size(); i++) begin
            write_reg(ADDR_OPA, 32'(vec_a[i]), RESP_OKAY);
            write_reg(ADDR_OPB, 32'(vec_b[i]), RESP_OKAY);
            write_reg(ADDR_CMD, {27'b0, vec_cmd[i]}, RESP_OKAY);  // answered after capture
            read_reg(ADDR_RESULT, RESP_OKAY, word);
            check_result("result", word[data_w-1:0], vec_res[i]);
            read_reg(ADDR_FLAGS, RESP_OKAY, word);
            check_flags("flags", word[3:0], vec_flags[i]);
            read_reg(ADDR_OPA, RESP_OKAY, word);
            check_result("opa", word[data_w-1:0], vec_a[i]);
            read_reg(ADDR_OPB, RESP_OKAY, word);
            check_result("opb", word[data_w-1:0], vec_b[i]);
            read_reg(ADDR_CMD, RESP_OKAY, word);
            check_cmd("cmd", alu_ctrl_t'(word[4:0]), vec_cmd[i]);
        end

        // a held back response blocks the next write until it is taken
        write_under_backpressure(ADDR_OPA, 32'h00ff, 32'h0f0f);

        // with a new operand in place a stray write must neither start the ALU nor land in OPA
        write_reg(ADDR_UNKNOWN, 32'h5a5a, RESP_SLVERR);
        read_reg(ADDR_UNKNOWN, RESP_SLVERR, word);
        check_result("rdata", word[data_w-1:0], '0);
        read_reg(ADDR_RESULT, RESP_OKAY, word);
        check_result("result", word[data_w-1:0], vec_res[vec_res.size()-1]);
        read_reg(ADDR_OPA, RESP_OKAY, word);
        check_result("opa", word[data_w-1:0], data_w'(32'h0f0f));

        $display("TEST OK");
        $finish;
    end

endmodule

// ==== flist.f ====
hw/alu_pkg.sv
hw/alu_slice.sv
hw/alu_axil_regs.sv
hw/alu_result_collect.sv
hw/alu_coproc_top.sv
sim/alu_coproc_tb.sv

// ==== Makefile ====
VERILATOR := verilator
TOP       := alu_coproc_tb
FLIST     := flist.f
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0
OBJ_DIR   := obj_dir

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FLIST))

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# the vector file path is relative to the project root, so run from here
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx 'TEST OK'

clean:
	rm -rf $(OBJ_DIR)

// ==== sim/alu_vectors.txt ====
# columns in hex: command a b result flags
# flags: bit 0 carry, bit 1 zero, bit 2 all ones, bit 3 sign
00 1234 4321 5555 0
00 ffff 0001 0000 3
10 7fff 0000 8000 8
00 4321 4321 8642 8
00 c003 c003 8006 9
18 5000 1234 3dcc 1
18 1234 5000 c234 8
18 abcd abcd 0000 3
04 f0f0 3c3c cccc 8
04 5a5a 5a5a 0000 2
0c f0f0 3c3c 3333 0
0c 0000 0000 ffff c
05 ff00 0ff0 0f00 0
06 ff00 00ff ffff c
06 0000 0000 0000 2
07 1111 8001 4000 0
17 0000 0002 8001 8
07 0000 0001 0000 2
08 0010 0005 000a 1
08 0005 0010 fff4 8
08 1234 1234 ffff c
